// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mpf_top \
		-f all.f --Mdir obj_dir -o tb_mpf_top
	./obj_dir/tb_mpf_top > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+sim
hdl/mpf_pkg.sv
hdl/wr_heap_ctrl.sv
hdl/wr_beat_tracker.sv
hdl/edge_afu.sv
hdl/req_pipe.sv
hdl/edge_fiu.sv
hdl/mpf_top.sv
sim/tb_mpf_top.sv

// File: hdl/edge_afu.sv
/*
 * Accelerator-side edge: parks every write beat in the heap, forwards one
 * control flit per packet and registers almost-full toward the accelerator
 */
`timescale 1ns/1ps

module edge_afu
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            c1_valid,
    input  logic                            c1_sop,
    input  logic [mpf_pkg::CL_LEN_W-1:0]    c1_cl_len,
    input  logic [mpf_pkg::ADDR_W-1:0]      c1_addr,
    input  logic [mpf_pkg::DATA_W-1:0]      c1_data,
    output logic                            c1_almost_full,
    output logic                            heap_wen,
    output logic [mpf_pkg::HEAP_IDX_W-1:0]  heap_widx,
    output logic [mpf_pkg::CL_LEN_W-1:0]    heap_wbeat,
    output logic [mpf_pkg::DATA_W-1:0]      heap_wdata,
    output logic                            alloc,
    input  logic [mpf_pkg::HEAP_IDX_W-1:0]  alloc_idx,
    input  logic                            not_full,
    output logic                            enq,
    output logic                            enq_sop,
    output logic [mpf_pkg::CL_LEN_W-1:0]    enq_cl_len,
    output logic [mpf_pkg::ADDR_W-1:0]      enq_addr,
    output mpf_pkg::t_line_word             enq_word,
    input  logic                            pipe_almost_full,
    output logic                            format_error
);

    logic                         eop;
    logic                         packet_active;
    logic [mpf_pkg::CL_LEN_W-1:0] beat_num;
    logic                         in_packet;
    logic                         wr_almost_full;
    logic                         sticky_full;

    wr_beat_tracker tracker0
    (
        .clk           (clk),
        .reset         (reset),
        .c1_valid      (c1_valid),
        .c1_sop        (c1_sop),
        .c1_cl_len     (c1_cl_len),
        .c1_addr       (c1_addr),
        .eop           (eop),
        .packet_active (packet_active),
        .beat_num      (beat_num),
        .format_error  (format_error)
    );

    // ============================================================
    // Heap write and control flit
    // ============================================================

    // Every beat lands in the packet's entry, slot chosen by beat number
    assign heap_wen = c1_valid;
    assign heap_widx = alloc_idx;
    assign heap_wbeat = beat_num;
    assign heap_wdata = c1_data;

    // The entry is claimed once the packet's data is fully stored
    assign alloc = eop;

    // One flit per packet, sent with the last beat
    assign enq = eop;
    assign enq_sop = 1'b1;
    assign enq_cl_len = c1_cl_len;

    // Xor with the length rewinds the last beat's address to the start
    assign enq_addr = {c1_addr[mpf_pkg::ADDR_W-1:mpf_pkg::CL_LEN_W],
                       c1_addr[mpf_pkg::CL_LEN_W-1:0] ^ c1_cl_len};

    // The data is gone from the flit and the heap index rides in its place
    always_comb
    begin
        enq_word = '0;
        enq_word.idx.heap_idx = alloc_idx;
    end

    // ============================================================
    // Almost-full toward the accelerator
    // ============================================================

    // A packet stays open after this cycle unless this beat closes it
    assign in_packet = (packet_active || c1_valid) && !eop;
    assign wr_almost_full = pipe_almost_full || !not_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            c1_almost_full <= 1'b1;
            sticky_full <= 1'b0;
        end
        else
        begin
            // Raised between packets only, so an open packet can always drain
            c1_almost_full <= wr_almost_full && (!in_packet || sticky_full);

            // Remembers that almost-full was seen with no packet open
            if (!wr_almost_full)
                sticky_full <= 1'b0;
            else if (!in_packet)
                sticky_full <= 1'b1;
        end
    end

endmodule

// File: hdl/edge_fiu.sv
/*
 * Host-side edge: owns the write-heap data and rebuilds each packet beat
 * by beat from its control flit, then frees the heap entry
 */
`timescale 1ns/1ps

module edge_fiu
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            heap_wen,
    input  logic [mpf_pkg::HEAP_IDX_W-1:0]  heap_widx,
    input  logic [mpf_pkg::CL_LEN_W-1:0]    heap_wbeat,
    input  logic [mpf_pkg::DATA_W-1:0]      heap_wdata,
    input  logic                            head_valid,
    input  logic [mpf_pkg::CL_LEN_W-1:0]    head_cl_len,
    input  logic [mpf_pkg::ADDR_W-1:0]      head_addr,
    input  mpf_pkg::t_line_word             head_word,
    output logic                            deq,
    output logic                            free,
    output logic [mpf_pkg::HEAP_IDX_W-1:0]  free_idx,
    input  logic                            fiu_almost_full,
    output logic                            fiu_valid,
    output logic                            fiu_sop,
    output logic [mpf_pkg::CL_LEN_W-1:0]    fiu_cl_len,
    output logic [mpf_pkg::ADDR_W-1:0]      fiu_addr,
    output logic [mpf_pkg::DATA_W-1:0]      fiu_data
);

    // Heap data, one row of MAX_BEATS lines per entry
    logic [mpf_pkg::DATA_W-1:0] heap_mem [mpf_pkg::HEAP_ENTRIES][mpf_pkg::MAX_BEATS];

    // State machine: idle between packets, sending while beats remain
    logic                           sending;
    logic [mpf_pkg::HEAP_IDX_W-1:0] cur_idx;
    logic [mpf_pkg::ADDR_W-1:0]     cur_addr;
    logic [mpf_pkg::CL_LEN_W-1:0]   cur_cl_len;
    logic [mpf_pkg::CL_LEN_W-1:0]   beat_cnt;

    // Selected beat for this cycle, from the head flit or the open packet
    logic                           emit;
    logic [mpf_pkg::HEAP_IDX_W-1:0] idx_sel;
    logic [mpf_pkg::ADDR_W-1:0]     start_sel;
    logic [mpf_pkg::CL_LEN_W-1:0]   len_sel;
    logic [mpf_pkg::CL_LEN_W-1:0]   beat_sel;
    logic                           last_sel;

    always_ff @(posedge clk)
    begin
        if (heap_wen)
            heap_mem[heap_widx][heap_wbeat] <= heap_wdata;
    end

    // A new packet is taken only when idle and the host has room
    assign deq = head_valid && !fiu_almost_full && !sending;
    assign emit = deq || sending;

    assign idx_sel = sending ? cur_idx : head_word.idx.heap_idx;
    assign start_sel = sending ? cur_addr : head_addr;
    assign len_sel = sending ? cur_cl_len : head_cl_len;
    assign beat_sel = sending ? beat_cnt : '0;
    assign last_sel = (beat_sel == len_sel);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sending <= 1'b0;
            fiu_valid <= 1'b0;
            free <= 1'b0;
        end
        else
        begin
            fiu_valid <= emit;
            // Entry goes back to the allocator with the packet's last beat
            free <= emit && last_sel;
            if (emit)
                sending <= !last_sel;
        end
    end

    // ============================================================
    // Rebuilt beat and packet context
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            fiu_sop <= !sending;
            fiu_cl_len <= len_sel;
            fiu_addr <= start_sel + mpf_pkg::ADDR_W'(beat_sel);
            fiu_data <= heap_mem[idx_sel][beat_sel];
            free_idx <= idx_sel;

            cur_idx <= idx_sel;
            cur_addr <= start_sel;
            cur_cl_len <= len_sel;
            beat_cnt <= beat_sel + 1'b1;
        end
    end

endmodule

// File: hdl/mpf_pkg.sv
/*
 * Memory-request shim write path: shared sizes and the line word
 * that carries either write data or a write-heap index
 */
package mpf_pkg;

    // Cache-line address and data widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 64;

    // Encoded packet length: 0, 1 or 3 for 1, 2 or 4 beats
    localparam int CL_LEN_W = 2;
    localparam int MAX_BEATS = 4;

    // Write heap, one entry per packet of up to MAX_BEATS lines
    localparam int HEAP_ENTRIES = 16;
    localparam int HEAP_IDX_W = 4;

    // Middle pipeline sizing
    localparam int PIPE_DEPTH = 8;
    localparam int ALM_FULL_THRESHOLD = 2;

    // The heap keeps room for the almost-full window plus one whole packet,
    // since almost-full is never raised in the middle of a packet
    localparam int MIN_FREE_SLOTS = ALM_FULL_THRESHOLD + MAX_BEATS + 1;

    // Index view of a line word. Only the low bits are meaningful
    typedef struct packed {
        logic [DATA_W-HEAP_IDX_W-1:0] pad;
        logic [HEAP_IDX_W-1:0]        heap_idx;
    } t_idx_word;

    // A line word is either a full line of data or a heap reference
    typedef union packed {
        logic [DATA_W-1:0] line;
        t_idx_word         idx;
    } t_line_word;

endpackage

// File: hdl/mpf_top.sv
/*
 * Write path top: accelerator edge, heap allocator, middle pipeline
 * and host edge
 */
`timescale 1ns/1ps

module mpf_top
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          c1_valid,
    input  logic                          c1_sop,
    input  logic [mpf_pkg::CL_LEN_W-1:0]  c1_cl_len,
    input  logic [mpf_pkg::ADDR_W-1:0]    c1_addr,
    input  logic [mpf_pkg::DATA_W-1:0]    c1_data,
    output logic                          c1_almost_full,
    output logic                          fiu_valid,
    output logic                          fiu_sop,
    output logic [mpf_pkg::CL_LEN_W-1:0]  fiu_cl_len,
    output logic [mpf_pkg::ADDR_W-1:0]    fiu_addr,
    output logic [mpf_pkg::DATA_W-1:0]    fiu_data,
    input  logic                          fiu_almost_full,
    output logic                          format_error
);

    // Heap write port from the accelerator edge
    logic                           heap_wen;
    logic [mpf_pkg::HEAP_IDX_W-1:0] heap_widx;
    logic [mpf_pkg::CL_LEN_W-1:0]   heap_wbeat;
    logic [mpf_pkg::DATA_W-1:0]     heap_wdata;

    // Allocator
    logic                           alloc;
    logic [mpf_pkg::HEAP_IDX_W-1:0] alloc_idx;
    logic                           not_full;
    logic                           free;
    logic [mpf_pkg::HEAP_IDX_W-1:0] free_idx;

    // Pipeline in and out
    logic                           enq;
    logic [mpf_pkg::CL_LEN_W-1:0]   enq_cl_len;
    logic [mpf_pkg::ADDR_W-1:0]     enq_addr;
    mpf_pkg::t_line_word            enq_word;
    logic                           pipe_almost_full;
    logic                           head_valid;
    logic [mpf_pkg::CL_LEN_W-1:0]   head_cl_len;
    logic [mpf_pkg::ADDR_W-1:0]     head_addr;
    mpf_pkg::t_line_word            head_word;
    logic                           deq;

    // The pipeline stores no start flag, every flit in it opens a packet
    edge_afu afu0
    (
        .clk              (clk),
        .reset            (reset),
        .c1_valid         (c1_valid),
        .c1_sop           (c1_sop),
        .c1_cl_len        (c1_cl_len),
        .c1_addr          (c1_addr),
        .c1_data          (c1_data),
        .c1_almost_full   (c1_almost_full),
        .heap_wen         (heap_wen),
        .heap_widx        (heap_widx),
        .heap_wbeat       (heap_wbeat),
        .heap_wdata       (heap_wdata),
        .alloc            (alloc),
        .alloc_idx        (alloc_idx),
        .not_full         (not_full),
        .enq              (enq),
        .enq_sop          (),
        .enq_cl_len       (enq_cl_len),
        .enq_addr         (enq_addr),
        .enq_word         (enq_word),
        .pipe_almost_full (pipe_almost_full),
        .format_error     (format_error)
    );

    wr_heap_ctrl heap_ctrl0
    (
        .clk       (clk),
        .reset     (reset),
        .alloc     (alloc),
        .not_full  (not_full),
        .alloc_idx (alloc_idx),
        .free      (free),
        .free_idx  (free_idx)
    );

    req_pipe pipe0
    (
        .clk         (clk),
        .reset       (reset),
        .enq         (enq),
        .enq_cl_len  (enq_cl_len),
        .enq_addr    (enq_addr),
        .enq_word    (enq_word),
        .almost_full (pipe_almost_full),
        .head_valid  (head_valid),
        .head_cl_len (head_cl_len),
        .head_addr   (head_addr),
        .head_word   (head_word),
        .deq         (deq)
    );

    edge_fiu fiu0
    (
        .clk             (clk),
        .reset           (reset),
        .heap_wen        (heap_wen),
        .heap_widx       (heap_widx),
        .heap_wbeat      (heap_wbeat),
        .heap_wdata      (heap_wdata),
        .head_valid      (head_valid),
        .head_cl_len     (head_cl_len),
        .head_addr       (head_addr),
        .head_word       (head_word),
        .deq             (deq),
        .free            (free),
        .free_idx        (free_idx),
        .fiu_almost_full (fiu_almost_full),
        .fiu_valid       (fiu_valid),
        .fiu_sop         (fiu_sop),
        .fiu_cl_len      (fiu_cl_len),
        .fiu_addr        (fiu_addr),
        .fiu_data        (fiu_data)
    );

endmodule

// File: hdl/req_pipe.sv
/*
 * Middle pipeline: circular FIFO of control flits with an almost-full
 * level raised a few slots before it fills
 */
`timescale 1ns/1ps

module req_pipe
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enq,
    input  logic [mpf_pkg::CL_LEN_W-1:0]    enq_cl_len,
    input  logic [mpf_pkg::ADDR_W-1:0]      enq_addr,
    input  mpf_pkg::t_line_word             enq_word,
    output logic                            almost_full,
    output logic                            head_valid,
    output logic [mpf_pkg::CL_LEN_W-1:0]    head_cl_len,
    output logic [mpf_pkg::ADDR_W-1:0]      head_addr,
    output mpf_pkg::t_line_word             head_word,
    input  logic                            deq
);

    localparam int PTR_W = $clog2(mpf_pkg::PIPE_DEPTH);

    // Flit storage. Start of packet is implied for every entry
    logic [mpf_pkg::CL_LEN_W-1:0] cl_len_mem [mpf_pkg::PIPE_DEPTH];
    logic [mpf_pkg::ADDR_W-1:0]   addr_mem   [mpf_pkg::PIPE_DEPTH];
    mpf_pkg::t_line_word          word_mem   [mpf_pkg::PIPE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign head_valid = (count != '0);
    assign head_cl_len = cl_len_mem[rd_ptr];
    assign head_addr = addr_mem[rd_ptr];
    assign head_word = word_mem[rd_ptr];

    // High with ALM_FULL_THRESHOLD or fewer slots left
    assign almost_full = (count >= mpf_pkg::PIPE_DEPTH - mpf_pkg::ALM_FULL_THRESHOLD);

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            cl_len_mem[wr_ptr] <= enq_cl_len;
            addr_mem[wr_ptr] <= enq_addr;
            word_mem[wr_ptr] <= enq_word;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq)
                rd_ptr <= rd_ptr + 1'b1;

            if (enq && !deq)
                count <= count + 1'b1;
            else if (deq && !enq)
                count <= count - 1'b1;
        end
    end

endmodule

// File: hdl/wr_beat_tracker.sv
/*
 * Multi-beat write tracker: numbers the beats of each packet, marks the
 * last one and latches a sticky error on any malformed beat sequence
 */
`timescale 1ns/1ps

module wr_beat_tracker
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          c1_valid,
    input  logic                          c1_sop,
    input  logic [mpf_pkg::CL_LEN_W-1:0]  c1_cl_len,
    input  logic [mpf_pkg::ADDR_W-1:0]    c1_addr,
    output logic                          eop,
    output logic                          packet_active,
    output logic [mpf_pkg::CL_LEN_W-1:0]  beat_num,
    output logic                          format_error
);

    logic [mpf_pkg::ADDR_W-1:0]   prev_addr;
    logic [mpf_pkg::CL_LEN_W-1:0] prev_cl_len;
    logic                         beat_bad;

    // The beat whose number matches the encoded length closes the packet
    assign eop = c1_valid && (beat_num == c1_cl_len);

    // ============================================================
    // Beat-format checks
    // ============================================================
    always_comb
    begin
        beat_bad = 1'b0;

        // Start flag only and always on the first beat
        if (c1_sop == packet_active)
            beat_bad = 1'b1;

        // Start address must be naturally aligned to the length
        if (c1_sop && ((c1_addr[mpf_pkg::CL_LEN_W-1:0] & c1_cl_len) != '0))
            beat_bad = 1'b1;

        // Three-beat packets do not exist
        if (c1_cl_len == 2'd2)
            beat_bad = 1'b1;

        // Later beats keep the length and step the address by one line
        if (packet_active && (c1_cl_len != prev_cl_len))
            beat_bad = 1'b1;
        if (packet_active && (c1_addr != prev_addr + 1'b1))
            beat_bad = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            packet_active <= 1'b0;
            beat_num <= '0;
            format_error <= 1'b0;
        end
        else if (c1_valid)
        begin
            packet_active <= !eop;
            beat_num <= eop ? '0 : beat_num + 1'b1;
            format_error <= format_error || beat_bad;
        end
    end

    // Previous beat, only compared while a packet is open
    always_ff @(posedge clk)
    begin
        if (c1_valid)
        begin
            prev_addr <= c1_addr;
            prev_cl_len <= c1_cl_len;
        end
    end

endmodule

// File: hdl/wr_heap_ctrl.sv
/*
 * Write-heap allocator: hands out entry indices from a circular free
 * list and takes them back as packets leave toward the host
 */
`timescale 1ns/1ps

module wr_heap_ctrl
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            alloc,
    output logic                            not_full,
    output logic [mpf_pkg::HEAP_IDX_W-1:0]  alloc_idx,
    input  logic                            free,
    input  logic [mpf_pkg::HEAP_IDX_W-1:0]  free_idx
);

    // Circular list of free indices with head and tail pointers
    logic [mpf_pkg::HEAP_IDX_W-1:0] free_list [mpf_pkg::HEAP_ENTRIES];
    logic [mpf_pkg::HEAP_IDX_W-1:0] head_ptr;
    logic [mpf_pkg::HEAP_IDX_W-1:0] tail_ptr;
    logic [mpf_pkg::HEAP_IDX_W:0]   free_cnt;
    logic [mpf_pkg::HEAP_IDX_W:0]   free_cnt_next;

    // The next index to hand out is always at the head
    assign alloc_idx = free_list[head_ptr];

    always_comb
    begin
        free_cnt_next = free_cnt;
        if (alloc && !free)
            free_cnt_next = free_cnt - 1'b1;
        else if (free && !alloc)
            free_cnt_next = free_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Every entry starts out free, in index order
            for (int i = 0; i < mpf_pkg::HEAP_ENTRIES; i++)
                free_list[i] <= mpf_pkg::HEAP_IDX_W'(i);
            head_ptr <= '0;
            tail_ptr <= '0;
            free_cnt <= (mpf_pkg::HEAP_IDX_W+1)'(mpf_pkg::HEAP_ENTRIES);
            not_full <= 1'b0;
        end
        else
        begin
            if (alloc)
                head_ptr <= head_ptr + 1'b1;

            // A returned index goes behind all the others still free
            if (free)
            begin
                free_list[tail_ptr] <= free_idx;
                tail_ptr <= tail_ptr + 1'b1;
            end

            free_cnt <= free_cnt_next;
            not_full <= (free_cnt_next > mpf_pkg::MIN_FREE_SLOTS);
        end
    end

endmodule

// File: sim/tb_tasks.svh
/*
 * Directed tests for the write-path shim, included into the testbench
 * module, with the small drivers they share
 */

    // Two reset cycles with the accelerator side idle
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        c1_valid = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic hold_host(input logic hold);
        fiu_almost_full = hold;
        host_held = hold;
    endtask

    task automatic wait_drain();
        while (exp_ctrl_q.size() != 0)
            @(negedge clk);
    endtask

    // One well-formed packet, back to back with the previous one if any.
    // The host should see sop on beat 0, start plus beat as address, same cl_len
    task automatic send_packet(input logic [mpf_pkg::CL_LEN_W-1:0] cl_len,
                               input logic [mpf_pkg::ADDR_W-1:0] start,
                               input logic wait_room);
        logic                       af_at_start;
        logic [mpf_pkg::DATA_W-1:0] data;
        while (wait_room && c1_almost_full)
            @(negedge clk);
        af_at_start = c1_almost_full;
        for (int b = 0; b <= cl_len; b++)
        begin
            // Almost-full may only rise mid-packet if it was up before the start
            if (b != 0)
            begin
                assert (af_at_start || !c1_almost_full)
                    else stop_on_error($sformatf("%s: c1_almost_full rose inside a packet",
                                                 cur_test));
            end
            assert (!format_error)
                else stop_on_error($sformatf("mismatch %s: format_error expected 0 actual 1",
                                             cur_test));
            data = {$random(seed), $random(seed)};
            c1_valid = 1'b1;
            c1_sop = (b == 0);
            c1_cl_len = cl_len;
            c1_addr = start + mpf_pkg::ADDR_W'(b);
            c1_data = data;
            exp_ctrl_q.push_back({b == 0, cl_len, c1_addr});
            exp_data_q.push_back(data);
            @(negedge clk);
        end
        c1_valid = 1'b0;
    endtask

    // A raw beat with no scoreboard entry, for the malformed sequences
    task automatic drive_beat(input logic sop, input logic [mpf_pkg::CL_LEN_W-1:0] cl_len,
                              input logic [mpf_pkg::ADDR_W-1:0] addr);
        c1_valid = 1'b1;
        c1_sop = sop;
        c1_cl_len = cl_len;
        c1_addr = addr;
        c1_data = {$random(seed), $random(seed)};
        @(negedge clk);
        c1_valid = 1'b0;
    endtask

    task automatic test_reset();
        int waited;
        cur_test = "reset";
        @(negedge clk);
        reset = 1'b1;
        repeat (2)
        begin
            @(negedge clk);
            assert (c1_almost_full)
                else stop_on_error("mismatch reset: c1_almost_full expected 1 actual 0");
            assert (!fiu_valid)
                else stop_on_error($sformatf("mismatch reset: fiu_valid expected 0 actual %b",
                                             fiu_valid));
            assert (!format_error)
                else stop_on_error($sformatf("mismatch reset: format_error expected 0 actual %b",
                                             format_error));
        end
        reset = 1'b0;
        waited = 0;
        while (c1_almost_full && waited < 3)
        begin
            @(negedge clk);
            waited++;
        end
        assert (!c1_almost_full)
            else stop_on_error("reset: c1_almost_full still high 3 cycles after reset");
    endtask

    task automatic test_single_writes();
        logic [31:0] rnd;
        cur_test = "single-beat writes";
        repeat (20)
        begin
            rnd = $random(seed);
            send_packet(2'd0, rnd[15:0], 1'b1);
        end
        wait_drain();
    endtask

    // Random mix of 2 and 4 beats, start address aligned to the length
    task automatic test_multi_beat_writes();
        logic [31:0]                  rnd;
        logic [mpf_pkg::CL_LEN_W-1:0] len;
        cur_test = "multi-beat writes";
        repeat (12)
        begin
            rnd = $random(seed);
            len = rnd[16] ? 2'd3 : 2'd1;
            send_packet(len, rnd[15:0] & ~{14'b0, len}, 1'b1);
        end
        wait_drain();
    endtask

    // Each round fills the pipeline with the host stalled, then drains it.
    // The packet that sees almost-full at its start is the last of its round
    task automatic test_back_pressure();
        int          sent;
        int          in_round;
        logic        af_seen;
        logic        af_expect;
        logic [31:0] rnd;
        cur_test = "back-pressure";
        sent = 0;
        while (sent < 30)
        begin
            hold_host(1'b1);
            in_round = 0;
            af_seen = 1'b0;
            while (!af_seen && sent < 30)
            begin
                af_seen = c1_almost_full;
                rnd = $random(seed);
                send_packet(2'd3, {rnd[15:2], 2'b00}, 1'b0);
                in_round++;
                sent++;
            end
            repeat (3) @(negedge clk);
            // One flit per held packet, so the pipeline level sets almost-full
            af_expect = (in_round >= mpf_pkg::PIPE_DEPTH - mpf_pkg::ALM_FULL_THRESHOLD);
            assert (c1_almost_full == af_expect)
                else stop_on_error($sformatf("mismatch %s: c1_almost_full expected %b actual %b",
                                             cur_test, af_expect, c1_almost_full));
            hold_host(1'b0);
            wait_drain();
        end
        assert (!format_error)
            else stop_on_error("mismatch back-pressure: format_error expected 0 actual 1");
    endtask

    // The flag must stay up until reset and be clear afterwards
    task automatic expect_sticky_error(input string case_name);
        repeat (4)
        begin
            assert (format_error)
                else stop_on_error($sformatf("mismatch %s, %s: format_error expected 1 actual %b",
                                             cur_test, case_name, format_error));
            @(negedge clk);
        end
        apply_reset();
        assert (!format_error)
            else stop_on_error($sformatf(
                "mismatch %s, %s: format_error after reset expected 0 actual 1",
                cur_test, case_name));
    endtask

    // Host is held so the malformed packets never reach the scoreboard
    task automatic test_format_errors();
        cur_test = "format errors";
        hold_host(1'b1);
        apply_reset();

        drive_beat(1'b0, 2'd0, 16'h0005);
        expect_sticky_error("beat without sop");

        drive_beat(1'b1, 2'd3, 16'h0021);
        drive_beat(1'b0, 2'd3, 16'h0022);
        drive_beat(1'b0, 2'd3, 16'h0023);
        drive_beat(1'b0, 2'd3, 16'h0024);
        expect_sticky_error("misaligned start");

        drive_beat(1'b1, 2'd1, 16'h0010);
        drive_beat(1'b0, 2'd1, 16'h0012);
        expect_sticky_error("address skip");

        hold_host(1'b0);
    endtask

// File: sim/tb_mpf_top.sv
/*
 * Testbench for the write-path shim: clock, reset, DUT, scoreboard of
 * expected host beats, run timeout and the directed test sequence
 */
`timescale 1ns/1ps

module tb_mpf_top;

    logic                           clk;
    logic                           reset;
    logic                           c1_valid;
    logic                           c1_sop;
    logic [mpf_pkg::CL_LEN_W-1:0]   c1_cl_len;
    logic [mpf_pkg::ADDR_W-1:0]     c1_addr;
    logic [mpf_pkg::DATA_W-1:0]     c1_data;
    logic                           c1_almost_full;
    logic                           fiu_valid;
    logic                           fiu_sop;
    logic [mpf_pkg::CL_LEN_W-1:0]   fiu_cl_len;
    logic [mpf_pkg::ADDR_W-1:0]     fiu_addr;
    logic [mpf_pkg::DATA_W-1:0]     fiu_data;
    logic                           fiu_almost_full;
    logic                           format_error;

    // Expected host beats. Control is {sop, cl_len, addr}, data kept in step
    logic [mpf_pkg::CL_LEN_W+mpf_pkg::ADDR_W:0] exp_ctrl_q [$];
    logic [mpf_pkg::DATA_W-1:0]                 exp_data_q [$];
    logic [mpf_pkg::CL_LEN_W+mpf_pkg::ADDR_W:0] got_ctrl;

    string  cur_test;
    integer seed;
    int     cycle_cnt = 0;

    // Mirrors fiu_almost_full, so no host beat may show up while it is set
    logic   host_held;

    mpf_top dut0
    (
        .clk             (clk),
        .reset           (reset),
        .c1_valid        (c1_valid),
        .c1_sop          (c1_sop),
        .c1_cl_len       (c1_cl_len),
        .c1_addr         (c1_addr),
        .c1_data         (c1_data),
        .c1_almost_full  (c1_almost_full),
        .fiu_valid       (fiu_valid),
        .fiu_sop         (fiu_sop),
        .fiu_cl_len      (fiu_cl_len),
        .fiu_addr        (fiu_addr),
        .fiu_data        (fiu_data),
        .fiu_almost_full (fiu_almost_full),
        .format_error    (format_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // The whole sequence needs roughly 600 cycles
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= 3000)
            stop_on_error("timeout: the tests did not finish within 3000 cycles");
    end

    // ============================================================
    // Scoreboard, sampled mid-cycle where the registered outputs are stable
    // ============================================================
    always @(negedge clk)
    begin
        if (!reset && fiu_valid)
        begin
            got_ctrl = {fiu_sop, fiu_cl_len, fiu_addr};
            assert (!host_held)
                else stop_on_error($sformatf("%s: host beat seen while fiu_almost_full was held",
                                             cur_test));
            assert (exp_ctrl_q.size() != 0)
                else stop_on_error($sformatf("%s: stray host beat with no packet outstanding",
                                             cur_test));
            assert (got_ctrl == exp_ctrl_q[0])
                else stop_on_error($sformatf("mismatch %s: sop/cl_len/addr expected %h actual %h",
                                             cur_test, exp_ctrl_q[0], got_ctrl));
            assert (fiu_data == exp_data_q[0])
                else stop_on_error($sformatf("mismatch %s: data expected %h actual %h",
                                             cur_test, exp_data_q[0], fiu_data));
            void'(exp_ctrl_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    end

    `include "tb_tasks.svh"

    // ============================================================
    // Test sequence
    // ============================================================
    initial
    begin
        seed = 93047;
        reset = 1'b1;
        c1_valid = 1'b0;
        c1_sop = 1'b0;
        c1_cl_len = '0;
        c1_addr = '0;
        c1_data = '0;
        fiu_almost_full = 1'b0;
        host_held = 1'b0;
        cur_test = "startup";

        test_reset();
        test_single_writes();
        test_multi_beat_writes();
        test_back_pressure();
        test_format_errors();

        // A quiet stretch lets any stray host beat surface
        cur_test = "end of run";
        repeat (10) @(negedge clk);
        if (exp_ctrl_q.size() == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
            stop_on_error($sformatf("%0d expected host beats never arrived", exp_ctrl_q.size()));
    end

endmodule
